// ==== Makefile ====
# Verilator build and run for the AXI memory testbench.

VERILATOR ?= verilator
TOP       ?= tb_axi_mem
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary -j 0
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# pass only if the simulation prints the pass message.
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "Everything OK"; then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

// ==== project.f ====
+incdir+tests
rtl/utils_pkg.sv
rtl/mem_bank.sv
rtl/axi_wr_stage.sv
rtl/axi_rd_stage.sv
rtl/axi_mem.sv
tests/tb_axi_mem.sv

// ==== rtl/axi_mem.sv ====
`default_nettype none

module axi_mem import utils_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // AW channel
  input  axi_id_t   awid,
  input  axi_addr_t awaddr,
  input  axi_len_t  awlen,
  input  axi_size_t awsize,
  input  logic      awvalid,
  output logic      awready,
  // W channel
  input  axi_data_t wdata,
  input  axi_strb_t wstrb,
  input  logic      wlast,
  input  logic      wvalid,
  output logic      wready,
  // B channel
  output axi_id_t   bid,
  output axi_resp_t bresp,
  output logic      bvalid,
  input  logic      bready,
  // AR channel
  input  axi_id_t   arid,
  input  axi_addr_t araddr,
  input  axi_len_t  arlen,
  input  axi_size_t arsize,
  input  logic      arvalid,
  output logic      arready,
  // R channel
  output axi_id_t   rid,
  output axi_data_t rdata,
  output axi_resp_t rresp,
  output logic      rlast,
  output logic      rvalid,
  input  logic      rready
);

  // RAM ports between the stages and the bank.
  logic       wr_en;
  word_addr_t wr_addr;
  axi_strb_t  wr_be;
  axi_data_t  wr_data;
  logic       rd_en;
  word_addr_t rd_addr;
  axi_data_t  rd_data;

  axi_wr_stage u_wr (.*);

  axi_rd_stage u_rd (.*);

  mem_bank u_mem (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_be   (wr_be),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== rtl/axi_rd_stage.sv ====
`default_nettype none

module axi_rd_stage import utils_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // AR channel
  input  axi_id_t    arid,
  input  axi_addr_t  araddr,
  input  axi_len_t   arlen,
  input  axi_size_t  arsize,
  input  logic       arvalid,
  output logic       arready,
  // R channel
  output axi_id_t    rid,
  output axi_data_t  rdata,
  output axi_resp_t  rresp,
  output logic       rlast,
  output logic       rvalid,
  input  logic       rready,
  // RAM read port
  output logic       rd_en,
  output word_addr_t rd_addr,
  input  axi_data_t  rd_data
);

  rd_state_t  state_ff;
  rd_state_t  next_state;
  axi_id_t    id_ff;
  word_addr_t word_ff;
  axi_len_t   rem_ff;
  axi_size_t  size_ff;
  logic [1:0] off_ff;
  axi_data_t  rdata_ff;
  logic       rvalid_ff;
  axi_strb_t  lanes;
  axi_data_t  lane_mask;
  logic       ar_hs;
  logic       r_hs;

  assign ar_hs = arvalid && arready;
  assign r_hs  = rvalid && rready;

  always_comb begin
    next_state = state_ff;
    case (state_ff)
      RD_IDLE: begin
        if (ar_hs) begin
          next_state = RD_FETCH;
        end
      end
      RD_FETCH: next_state = RD_DATA;
      RD_DATA: begin
        if (r_hs) begin
          next_state = (rem_ff == '0) ? RD_IDLE : RD_FETCH;
        end
      end
      default: next_state = RD_IDLE;
    endcase
  end

  // expand the lane enables to a bit mask.
  always_comb begin
    lanes = size_lanes(size_ff, off_ff);
    for (int i = 0; i < $bits(axi_strb_t); i++) begin
      lane_mask[i*8 +: 8] = {8{lanes[i]}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_ff  <= RD_IDLE;
      rvalid_ff <= 1'b0;
    end else begin
      state_ff <= next_state;
      // RAM data lands on the first RD_DATA cycle.
      if (state_ff == RD_DATA && !rvalid_ff) begin
        rvalid_ff <= 1'b1;
      end else if (r_hs) begin
        rvalid_ff <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      id_ff   <= arid;
      word_ff <= araddr[2 +: WORD_ADDR_W];
      rem_ff  <= arlen;
      size_ff <= arsize;
      off_ff  <= araddr[1:0];
    end else if (r_hs) begin
      word_ff <= word_ff + 1'b1;
      rem_ff  <= rem_ff - 1'b1;
      off_ff  <= '0;
    end
    if (state_ff == RD_DATA && !rvalid_ff) begin
      rdata_ff <= rd_data & lane_mask;
    end
  end

  assign arready = (state_ff == RD_IDLE);
  assign rd_en   = (state_ff == RD_FETCH);
  assign rd_addr = word_ff;
  assign rid     = id_ff;
  assign rdata   = rdata_ff;
  assign rresp   = AXI_OKAY;
  assign rvalid  = rvalid_ff;
  assign rlast   = rvalid_ff && (rem_ff == '0);

endmodule

`default_nettype wire

// ==== rtl/axi_wr_stage.sv ====
`default_nettype none

module axi_wr_stage import utils_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // AW channel
  input  axi_id_t    awid,
  input  axi_addr_t  awaddr,
  input  axi_len_t   awlen,
  input  axi_size_t  awsize,
  input  logic       awvalid,
  output logic       awready,
  // W channel
  input  axi_data_t  wdata,
  input  axi_strb_t  wstrb,
  input  logic       wlast,
  input  logic       wvalid,
  output logic       wready,
  // B channel
  output axi_id_t    bid,
  output axi_resp_t  bresp,
  output logic       bvalid,
  input  logic       bready,
  // RAM write port
  output logic       wr_en,
  output word_addr_t wr_addr,
  output axi_strb_t  wr_be,
  output axi_data_t  wr_data
);

  wr_state_t  state_ff;
  wr_state_t  next_state;
  axi_id_t    id_ff;
  word_addr_t word_ff;
  axi_len_t   len_ff;
  axi_len_t   cnt_ff;
  logic       aw_hs;
  logic       w_hs;
  logic       b_hs;
  logic       last_beat;

  assign aw_hs     = awvalid && awready;
  assign w_hs      = wvalid && wready;
  assign b_hs      = bvalid && bready;
  // the burst ends on wlast or on the beat count.
  assign last_beat = wlast || (cnt_ff == len_ff);

  always_comb begin
    next_state = state_ff;
    case (state_ff)
      WR_IDLE: begin
        if (aw_hs) begin
          next_state = WR_DATA;
        end
      end
      WR_DATA: begin
        if (w_hs && last_beat) begin
          next_state = WR_RESP;
        end
      end
      WR_RESP: begin
        if (b_hs) begin
          next_state = WR_IDLE;
        end
      end
      default: next_state = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_ff <= WR_IDLE;
    end else begin
      state_ff <= next_state;
    end
  end

  // burst context steps one word per accepted beat.
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_ff   <= awid;
      word_ff <= awaddr[2 +: WORD_ADDR_W];
      len_ff  <= awlen;
      cnt_ff  <= '0;
    end else if (w_hs) begin
      word_ff <= word_ff + 1'b1;
      cnt_ff  <= cnt_ff + 1'b1;
    end
  end

  assign awready = (state_ff == WR_IDLE);
  assign wready  = (state_ff == WR_DATA);
  assign bvalid  = (state_ff == WR_RESP);
  assign bid     = id_ff;
  assign bresp   = AXI_OKAY;

  assign wr_en   = w_hs;
  assign wr_addr = word_ff;
  assign wr_be   = wstrb;
  assign wr_data = wdata;

endmodule

`default_nettype wire

// ==== rtl/mem_bank.sv ====
`default_nettype none

module mem_bank import utils_pkg::*; (
  input  logic       clk,
  input  logic       wr_en,
  input  word_addr_t wr_addr,
  input  axi_strb_t  wr_be,
  input  axi_data_t  wr_data,
  input  logic       rd_en,
  input  word_addr_t rd_addr,
  output axi_data_t  rd_data
);

  axi_data_t mem [NUM_WORDS];

  // byte-wise write port.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < $bits(axi_strb_t); i++) begin
        if (wr_be[i]) begin
          mem[wr_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
        end
      end
    end
  end

  // registered read, holds when idle.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/utils_pkg.sv ====
`default_nettype none

package utils_pkg;

  // memory sizing.
  localparam int MEM_KB      = 4;
  localparam int NUM_WORDS   = MEM_KB * 256;
  localparam int WORD_ADDR_W = $clog2(NUM_WORDS);

  // bus widths.
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_ID_W   = 4;

  typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [AXI_DATA_W/8-1:0] axi_strb_t;
  typedef logic [AXI_ID_W-1:0]     axi_id_t;
  typedef logic [7:0]              axi_len_t;
  typedef logic [2:0]              axi_size_t;
  typedef logic [1:0]              axi_resp_t;
  typedef logic [WORD_ADDR_W-1:0]  word_addr_t;

  localparam axi_resp_t AXI_OKAY = 2'd0;

  localparam axi_size_t AXI_BYTE      = 3'd0;
  localparam axi_size_t AXI_HALF_WORD = 3'd1;
  localparam axi_size_t AXI_WORD      = 3'd2;

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_DATA} rd_state_t;

  // active byte lanes of a beat for a given size and byte offset.
  function automatic axi_strb_t size_lanes(axi_size_t size, logic [1:0] offset);
    axi_strb_t lanes;
    case (size)
      AXI_BYTE:      lanes = 4'b0001;
      AXI_HALF_WORD: lanes = 4'b0011;
      AXI_WORD:      lanes = 4'b1111;
      default:       lanes = 4'b1111;
    endcase
    // lanes past the top of the word fall off.
    return axi_strb_t'(lanes << offset);
  endfunction

endpackage

`default_nettype wire

// ==== tests/tb_axi_mem_tasks.svh ====
// expected lanes of a read beat for its size and byte offset.
function automatic axi_data_t read_mask(input axi_size_t size, input int offset);
  logic [63:0] wide;
  case (size)
    AXI_BYTE:      wide = 64'h0000_00ff;
    AXI_HALF_WORD: wide = 64'h0000_ffff;
    default:       wide = 64'hffff_ffff;
  endcase
  wide = wide << (8 * offset);
  return wide[31:0];
endfunction

// full-word INCR write burst of random data that is mirrored into ref_mem.
task automatic write_burst(input axi_id_t id, input axi_addr_t addr, input int beats,
                           input logic rand_strb, input logic stall);
  int         wait_cnt;
  word_addr_t idx;
  axi_data_t  data;
  axi_strb_t  strb;
  awid    = id;
  awaddr  = addr;
  awlen   = axi_len_t'(beats - 1);
  awsize  = AXI_WORD;
  awvalid = 1'b1;
  wait_cnt = 0;
  while (!awready && wait_cnt < TIMEOUT) begin
    step();
    wait_cnt++;
  end
  if (!awready) note_timeout("no awready within timeout");
  step();
  awvalid = 1'b0;
  for (int i = 0; i < beats; i++) begin
    idx  = word_addr_t'((int'(addr[31:2]) + i) % NUM_WORDS);
    data = take_bits(32);
    strb = rand_strb ? axi_strb_t'(take_bits(4)) : 4'hf;
    if (stall && take_bits(1) == 32'd0) begin
      wvalid = 1'b0;
      step();
    end
    wdata  = data;
    wstrb  = strb;
    wlast  = (i == beats - 1);
    wvalid = 1'b1;
    wait_cnt = 0;
    while (!wready && wait_cnt < TIMEOUT) begin
      step();
      wait_cnt++;
    end
    if (!wready) note_timeout("no wready within timeout");
    step();
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
    end
  end
  wvalid = 1'b0;
  wlast  = 1'b0;
  wait_cnt = 0;
  while (!bvalid && wait_cnt < TIMEOUT) begin
    step();
    wait_cnt++;
  end
  if (!bvalid) note_timeout("no bvalid within timeout");
  if (stall && take_bits(1) == 32'd0) begin
    step();
    check("bvalid", 32'(bvalid), 32'd1);
    check("awready", 32'(awready), 32'd0);
  end
  check("bid", 32'(bid), 32'(id));
  check("bresp", 32'(bresp), 32'(AXI_OKAY));
  bready = 1'b1;
  step();
  bready = 1'b0;
endtask

// INCR read burst that compares each beat with the masked reference word.
task automatic read_burst(input axi_id_t id, input axi_addr_t addr, input int beats,
                          input axi_size_t size, input logic stall);
  int         wait_cnt;
  word_addr_t idx;
  axi_data_t  expected;
  axi_data_t  held;
  arid    = id;
  araddr  = addr;
  arlen   = axi_len_t'(beats - 1);
  arsize  = size;
  arvalid = 1'b1;
  wait_cnt = 0;
  while (!arready && wait_cnt < TIMEOUT) begin
    step();
    wait_cnt++;
  end
  if (!arready) note_timeout("no arready within timeout");
  step();
  arvalid = 1'b0;
  for (int i = 0; i < beats; i++) begin
    idx      = word_addr_t'((int'(addr[31:2]) + i) % NUM_WORDS);
    expected = ref_mem[idx] & read_mask(size, (i == 0) ? int'(addr[1:0]) : 0);
    wait_cnt = 0;
    while (!rvalid && wait_cnt < TIMEOUT) begin
      step();
      wait_cnt++;
    end
    if (!rvalid) note_timeout("no rvalid within timeout");
    if (stall && take_bits(1) == 32'd0) begin
      held = rdata;
      step();
      check("rvalid", 32'(rvalid), 32'd1);
      check("rdata held", rdata, held);
    end
    check("rdata", rdata, expected);
    check("rid", 32'(rid), 32'(id));
    check("rresp", 32'(rresp), 32'(AXI_OKAY));
    check("rlast", 32'(rlast), 32'(i == beats - 1));
    rready = 1'b1;
    step();
    rready = 1'b0;
  end
endtask

task automatic reset_values();
  check("awready", 32'(awready), 32'd1);
  check("arready", 32'(arready), 32'd1);
  check("wready", 32'(wready), 32'd0);
  check("bvalid", 32'(bvalid), 32'd0);
  check("rvalid", 32'(rvalid), 32'd0);
endtask

task automatic single_word_roundtrip();
  write_burst(4'h5, 32'h0000_0010, 1, 1'b0, 1'b0);
  read_burst(4'ha, 32'h0000_0010, 1, AXI_WORD, 1'b0);
endtask

task automatic strobed_writes();
  write_burst(4'h1, 32'h0000_0100, 4, 1'b0, 1'b0);
  for (int i = 0; i < 8; i++) begin
    write_burst(axi_id_t'(i), 32'h0000_0100 + 32'(4 * (i % 4)), 1, 1'b1, 1'b0);
  end
  read_burst(4'h2, 32'h0000_0100, 4, AXI_WORD, 1'b0);
endtask

task automatic size_masked_reads();
  write_burst(4'h3, 32'h0000_0200, 1, 1'b0, 1'b0);
  for (int off = 0; off < 4; off++) begin
    read_burst(axi_id_t'(off), 32'h0000_0200 + 32'(off), 1, AXI_BYTE, 1'b0);
    read_burst(axi_id_t'(off + 4), 32'h0000_0200 + 32'(off), 1, AXI_HALF_WORD, 1'b0);
  end
endtask

task automatic burst_with_wrap();
  int beats;
  beats = int'(take_bits(4)) + 1;
  write_burst(4'h6, 32'h0000_0400, beats, 1'b0, 1'b0);
  read_burst(4'h7, 32'h0000_0400, beats, AXI_WORD, 1'b0);
  // the last two words of memory wrap to words 0 and 1.
  write_burst(4'h8, axi_addr_t'((NUM_WORDS - 2) * 4), 4, 1'b0, 1'b0);
  read_burst(4'h9, axi_addr_t'((NUM_WORDS - 2) * 4), 4, AXI_WORD, 1'b0);
  read_burst(4'hb, 32'h0000_0000, 2, AXI_WORD, 1'b0);
endtask

task automatic stalled_traffic();
  int beats;
  for (int n = 0; n < 3; n++) begin
    beats = int'(take_bits(4)) + 1;
    write_burst(axi_id_t'(n), 32'h0000_0600, beats, 1'b1, 1'b1);
    read_burst(axi_id_t'(n + 8), 32'h0000_0600, beats, AXI_WORD, 1'b1);
  end
endtask

// ==== tests/tb_axi_mem.sv ====
`default_nettype none

module tb_axi_mem import utils_pkg::*; ();

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 5;
  localparam int          TIMEOUT      = 100;
  localparam logic [31:0] SEED         = 32'd69698;
  // right-shifting form of x^32 + x^22 + x^2 + x + 1.
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  logic      clk = 1'b0;
  logic      rst;
  axi_id_t   awid;
  axi_addr_t awaddr;
  axi_len_t  awlen;
  axi_size_t awsize;
  logic      awvalid;
  logic      awready;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      wlast;
  logic      wvalid;
  logic      wready;
  axi_id_t   bid;
  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;
  axi_id_t   arid;
  axi_addr_t araddr;
  axi_len_t  arlen;
  axi_size_t arsize;
  logic      arvalid;
  logic      arready;
  axi_id_t   rid;
  axi_data_t rdata;
  axi_resp_t rresp;
  logic      rlast;
  logic      rvalid;
  logic      rready;

  logic [31:0] lfsr_state = SEED;
  axi_data_t   ref_mem [NUM_WORDS];
  int          error_count = 0;
  int          timeout_count = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  axi_mem u_dut (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ LFSR_TAPS;
    end
    return shifted;
  endfunction

  // one LFSR step per bit handed out.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int k = 0; k < n; k++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return value;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
      error_count++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("%s", what);
    timeout_count++;
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  `include "tb_axi_mem_tasks.svh"

  initial begin
    rst     = 1'b1;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awsize  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arsize  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    reset_values();
    single_word_roundtrip();
    strobed_writes();
    size_masked_reads();
    burst_with_wrap();
    stalled_traffic();

    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
